// ==== src/fp16_pkg.sv ====
`default_nettype none

package fp16_pkg;

    // half precision layout: sign, 5-bit exponent, 10-bit fraction
    parameter int fp16_w = 16;
    parameter int exp_w = 5;
    parameter int frac_w = 10;

    // biased exponent range
    parameter int exp_bias = 15;
    // exponent 31 is left for infinity
    parameter int exp_max = 30;

    // raw fp16 word
    typedef logic [fp16_w-1:0] fp16_t;

endpackage

`default_nettype wire

// ==== src/fpu_op_pkg.sv ====
`default_nettype none

package fpu_op_pkg;

    // operations the unit accepts
    typedef enum logic [1:0] {
        op_mul  = 2'd0,
        op_sqr  = 2'd1,
        op_nmul = 2'd2
    } op_t;

    // default caller tag width
    parameter int tag_w = 4;

    // req to done, in cycles
    parameter int mul_lat = 2;

endpackage

`default_nettype wire

// ==== src/stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     nRST,
    input  logic     load,
    input  payload_t d,
    output payload_t q,
    output logic     valid
);

    // q holds between loads
    // valid is a one-cycle pulse after each load
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            q     <= '0;
            valid <= 1'b0;
        end else begin
            valid <= load;
            if (load) begin
                q <= d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/significand_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module significand_mul (
    input  logic [10:0] a,
    input  logic [10:0] b,
    output logic [12:0] product,
    output logic        carry,
    output logic        round_loss
);

    // partial product rows, one per bit of b
    logic [21:0] pp [11];

    // running sum and carry rows of the carry-save reduction
    logic [21:0] s_st [11];
    logic [21:0] c_st [11];

    // full 22-bit product after the final add
    logic [21:0] full;

    always_comb begin
        for (int i = 0; i < 11; i++) begin
            pp[i] = b[i] ? (22'(a) << i) : 22'd0;
        end
    end

    // 3:2 compression of each new row into the sum/carry pair
    // carries out of bit 21 can be dropped, product < 2^22
    always_comb begin
        s_st[0] = pp[0];
        c_st[0] = '0;
        for (int i = 1; i < 11; i++) begin
            s_st[i] = s_st[i-1] ^ c_st[i-1] ^ pp[i];
            c_st[i] = ((s_st[i-1] & c_st[i-1])
                     | (s_st[i-1] & pp[i])
                     | (c_st[i-1] & pp[i])) << 1;
        end
    end

    // single carry-propagate add of the last two rows
    assign full = s_st[10] + c_st[10];

    // bit 21 set means the product is in [2,4)
    assign carry = full[21];

    // keep 13 bits under the carry position
    assign product = full[20:8];

    // anything below is only needed as sticky info
    assign round_loss = |full[7:0];

endmodule

`default_nettype wire

// ==== src/exp_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module exp_adder (
    input  logic       carry,
    input  logic [4:0] exp1,
    input  logic [4:0] exp2,
    output logic [4:0] sum,
    output logic       ovf,
    output logic       unf
);
    import fp16_pkg::*;

    // range is -15 .. 48, 7 signed bits is enough
    logic signed [6:0] exp_wide;

    always_comb begin
        exp_wide = 7'(exp1) + 7'(exp2) + 7'(carry) - 7'(exp_bias);
    end

    // above the largest finite exponent
    assign ovf = exp_wide > exp_max;
    // exponent 0 or below, no subnormal results
    assign unf = exp_wide < 1;

    // saturate: all ones for infinity, zero for underflow
    always_comb begin
        if (ovf) begin
            sum = '1;
        end else if (unf) begin
            sum = '0;
        end else begin
            sum = exp_wide[exp_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== src/fp16_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp16_mul (
    input  logic            clk,
    input  logic            nRST,
    input  logic            start,
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    output fp16_pkg::fp16_t result,
    output logic            done,
    output logic            ovf,
    output logic            unf
);
    import fp16_pkg::*;

    // register 1 payload
    typedef struct packed {
        fp16_t op_a;
        fp16_t op_b;
    } operands_t;

    // register 2 payload, head = sign plus exponent
    typedef struct packed {
        logic [12:0]    product;
        logic           carry;
        logic           round_loss;
        logic [exp_w:0] a_head;
        logic [exp_w:0] b_head;
    } bundle_t;

    operands_t s1_d, s1_q;
    bundle_t   s2_d, s2_q;
    logic      s1_valid;

    logic [frac_w:0] sig_a, sig_b;
    logic [12:0]     mul_product;
    logic            mul_carry;
    logic            mul_round_loss;

    logic              res_sign;
    logic [exp_w-1:0]  exp_sum;
    logic              exp_ovf, exp_unf;
    logic [11:0]       frac_prod;
    logic              sticky;
    logic              round_up;
    logic [frac_w-1:0] frac_rnd;
    logic              zero_prod;

    // register 1: operand pair
    assign s1_d = '{op_a: a, op_b: b};

    stage_reg #(.payload_t(operands_t)) u_reg1 (
        .clk  (clk),
        .nRST (nRST),
        .load (start),
        .d    (s1_d),
        .q    (s1_q),
        .valid(s1_valid)
    );

    // implicit bit only for nonzero exponent, no renormalize
    assign sig_a = {|s1_q.op_a[fp16_w-2:frac_w], s1_q.op_a[frac_w-1:0]};
    assign sig_b = {|s1_q.op_b[fp16_w-2:frac_w], s1_q.op_b[frac_w-1:0]};

    significand_mul u_sig_mul (
        .a         (sig_a),
        .b         (sig_b),
        .product   (mul_product),
        .carry     (mul_carry),
        .round_loss(mul_round_loss)
    );

    // register 2: product plus the sign/exponent heads
    assign s2_d = '{product:    mul_product,
                    carry:      mul_carry,
                    round_loss: mul_round_loss,
                    a_head:     s1_q.op_a[fp16_w-1:frac_w],
                    b_head:     s1_q.op_b[fp16_w-1:frac_w]};

    stage_reg #(.payload_t(bundle_t)) u_reg2 (
        .clk  (clk),
        .nRST (nRST),
        .load (s1_valid),
        .d    (s2_d),
        .q    (s2_q),
        .valid(done)
    );

    assign res_sign = s2_q.a_head[exp_w] ^ s2_q.b_head[exp_w];

    exp_adder u_exp_add (
        .carry(s2_q.carry),
        .exp1 (s2_q.a_head[exp_w-1:0]),
        .exp2 (s2_q.b_head[exp_w-1:0]),
        .sum  (exp_sum),
        .ovf  (exp_ovf),
        .unf  (exp_unf)
    );

    // carry out: drop one more bit, exponent already bumped
    assign frac_prod = s2_q.carry ? s2_q.product[12:1] : s2_q.product[11:0];

    // bit shifted out on carry also counts as sticky
    assign sticky = frac_prod[0] | s2_q.round_loss | (s2_q.carry & s2_q.product[0]);

    // nearest even: round bit set and (sticky or odd lsb)
    assign round_up = frac_prod[1] & (sticky | frac_prod[2]);
    // all-ones fraction wraps to zero here
    assign frac_rnd = frac_prod[11:2] + frac_w'(round_up);

    // bits lost below the kept product still make it nonzero
    assign zero_prod = (s2_q.product == '0) && !s2_q.carry && !s2_q.round_loss;

    // flags only mean something for a nonzero product
    assign ovf = exp_ovf & ~zero_prod;
    assign unf = exp_unf & ~zero_prod;

    always_comb begin
        if (zero_prod) begin
            result = {res_sign, {(fp16_w-1){1'b0}}};
        end else if (exp_ovf || exp_unf) begin
            // infinity or zero, exponent already saturated
            result = {res_sign, exp_sum, {frac_w{1'b0}}};
        end else begin
            result = {res_sign, exp_sum, frac_rnd};
        end
    end

endmodule

`default_nettype wire

// ==== src/fpu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_ctrl #(
    parameter int TAG_W = fpu_op_pkg::tag_w
) (
    input  logic              clk,
    input  logic              nRST,
    input  logic              req,
    input  fpu_op_pkg::op_t   op,
    input  logic [TAG_W-1:0]  tag,
    input  fp16_pkg::fp16_t   a,
    input  fp16_pkg::fp16_t   b,
    input  logic              clr_flags,
    input  logic              done,
    input  logic              ovf,
    input  logic              unf,
    output logic              start,
    output fp16_pkg::fp16_t   mul_a,
    output fp16_pkg::fp16_t   mul_b,
    output logic [TAG_W-1:0]  result_tag,
    output logic              ovf_flag,
    output logic              unf_flag
);
    import fp16_pkg::*;
    import fpu_op_pkg::*;

    // one slot per multiplier stage
    logic [TAG_W-1:0] tag_pipe [mul_lat];

    // no handshake, req goes straight through
    assign start = req;
    assign mul_a = a;

    // operand select
    always_comb begin
        case (op)
            op_sqr:  mul_b = a;
            // flip b's sign, result sign follows
            op_nmul: mul_b = {~b[fp16_w-1], b[fp16_w-2:0]};
            default: mul_b = b;
        endcase
    end

    // slot 0 loads with the operands, later slots move every cycle
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < mul_lat; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            if (req) begin
                tag_pipe[0] <= tag;
            end
            for (int i = 1; i < mul_lat; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign result_tag = tag_pipe[mul_lat-1];

    // sticky flags, clear has priority
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            ovf_flag <= 1'b0;
            unf_flag <= 1'b0;
        end else if (clr_flags) begin
            ovf_flag <= 1'b0;
            unf_flag <= 1'b0;
        end else if (done) begin
            ovf_flag <= ovf_flag | ovf;
            unf_flag <= unf_flag | unf;
        end
    end

endmodule

`default_nettype wire

// ==== src/fpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_top #(
    parameter int TAG_W = fpu_op_pkg::tag_w
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             req,
    input  fpu_op_pkg::op_t  op,
    input  logic [TAG_W-1:0] tag,
    input  fp16_pkg::fp16_t  a,
    input  fp16_pkg::fp16_t  b,
    input  logic             clr_flags,
    output logic             done,
    output fp16_pkg::fp16_t  result,
    output logic [TAG_W-1:0] result_tag,
    output logic             ovf_flag,
    output logic             unf_flag
);

    // ctrl to multiplier
    logic            start;
    fp16_pkg::fp16_t mul_a, mul_b;
    // multiplier status back to ctrl
    logic            ovf, unf;

    fpu_ctrl #(.TAG_W(TAG_W)) u_ctrl (
        .clk       (clk),
        .nRST      (nRST),
        .req       (req),
        .op        (op),
        .tag       (tag),
        .a         (a),
        .b         (b),
        .clr_flags (clr_flags),
        .done      (done),
        .ovf       (ovf),
        .unf       (unf),
        .start     (start),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .result_tag(result_tag),
        .ovf_flag  (ovf_flag),
        .unf_flag  (unf_flag)
    );

    fp16_mul u_mul (
        .clk   (clk),
        .nRST  (nRST),
        .start (start),
        .a     (mul_a),
        .b     (mul_b),
        .result(result),
        .done  (done),
        .ovf   (ovf),
        .unf   (unf)
    );

endmodule

`default_nettype wire

// ==== verif/fpu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_props (
    input logic clk,
    input logic nRST,
    input logic req,
    input logic done,
    input logic ovf_flag,
    input logic unf_flag
);
    import fpu_op_pkg::*;

    // fixed latency, no stalls
    a_req_to_done: assert property (@(posedge clk) disable iff (!nRST)
        req |-> ##mul_lat done)
        else $error("done missing %0d cycles after req", mul_lat);

    // no spurious done
    a_done_has_req: assert property (@(posedge clk) disable iff (!nRST)
        done |-> $past(req, mul_lat))
        else $error("done without a matching req");

    // sticky flags only rise after a done cycle
    a_ovf_from_done: assert property (@(posedge clk) disable iff (!nRST)
        $rose(ovf_flag) |-> $past(done))
        else $error("ovf_flag set outside a done cycle");

    a_unf_from_done: assert property (@(posedge clk) disable iff (!nRST)
        $rose(unf_flag) |-> $past(done))
        else $error("unf_flag set outside a done cycle");

endmodule

bind fpu_top fpu_props u_props (
    .clk     (clk),
    .nRST    (nRST),
    .req     (req),
    .done    (done),
    .ovf_flag(ovf_flag),
    .unf_flag(unf_flag)
);

`default_nettype wire

// ==== verif/fpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;
    import fp16_pkg::*;
    import fpu_op_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int TAG_W = tag_w;
    localparam int NUM_VEC = 27;

    // one table row: stimulus plus the hand-derived response
    typedef struct packed {
        logic  req;
        op_t   op;
        fp16_t a;
        fp16_t b;
        logic  clr;
        fp16_t res;
        logic  ovf;
        logic  unf;
    } vec_t;

    // result still in flight, with the cycle it must show up
    typedef struct packed {
        fp16_t            res;
        logic [TAG_W-1:0] tag;
        logic             ovf;
        logic             unf;
        logic [31:0]      due;
    } pend_t;

    // req op a b clr | result ovf unf
    localparam vec_t VECS [NUM_VEC] = '{
        '{1'b1, op_mul,  16'h3E00, 16'h4000, 1'b0, 16'h4200, 1'b0, 1'b0},
        // 1.5 * 1.5, carry out
        '{1'b1, op_mul,  16'h3E00, 16'h3E00, 1'b0, 16'h4080, 1'b0, 1'b0},
        '{1'b1, op_mul,  16'hC000, 16'h3E00, 1'b0, 16'hC200, 1'b0, 1'b0},
        // square ignores b
        '{1'b1, op_sqr,  16'hBE00, 16'h1234, 1'b0, 16'h4080, 1'b0, 1'b0},
        '{1'b1, op_nmul, 16'h3E00, 16'h4000, 1'b0, 16'hC200, 1'b0, 1'b0},
        '{1'b1, op_nmul, 16'hC000, 16'hC000, 1'b0, 16'hC400, 1'b0, 1'b0},
        // ties: odd lsb rounds up, even lsb stays
        '{1'b1, op_mul,  16'h3C01, 16'h3E00, 1'b0, 16'h3E02, 1'b0, 1'b0},
        '{1'b1, op_mul,  16'h3C03, 16'h3E00, 1'b0, 16'h3E04, 1'b0, 1'b0},
        '{1'b1, op_sqr,  16'h3C01, 16'h0000, 1'b0, 16'h3C02, 1'b0, 1'b0},
        // all-ones fraction rounds up and wraps, exponent not bumped
        '{1'b1, op_mul,  16'h3BFE, 16'h3C01, 1'b0, 16'h3800, 1'b0, 1'b0},
        '{1'b1, op_sqr,  16'h3BFF, 16'h0000, 1'b0, 16'h3BFE, 1'b0, 1'b0},
        '{1'b0, op_mul,  16'h0000, 16'h0000, 1'b0, 16'h0000, 1'b0, 1'b0},
        // signed zeros, no flags
        '{1'b1, op_mul,  16'h0000, 16'h3E00, 1'b0, 16'h0000, 1'b0, 1'b0},
        '{1'b1, op_mul,  16'h8000, 16'h3E00, 1'b0, 16'h8000, 1'b0, 1'b0},
        // zero exponent, implicit bit 0
        '{1'b1, op_mul,  16'h0200, 16'h4A00, 1'b0, 16'h0F00, 1'b0, 1'b0},
        '{1'b1, op_mul,  16'h7800, 16'h4000, 1'b0, 16'h7C00, 1'b1, 1'b0},
        '{1'b1, op_mul,  16'h3C00, 16'h3C00, 1'b0, 16'h3C00, 1'b0, 1'b0},
        '{1'b0, op_mul,  16'h0000, 16'h0000, 1'b0, 16'h0000, 1'b0, 1'b0},
        '{1'b1, op_nmul, 16'h7800, 16'h4000, 1'b0, 16'hFC00, 1'b1, 1'b0},
        '{1'b1, op_mul,  16'h8400, 16'h0400, 1'b0, 16'h8000, 1'b0, 1'b1},
        '{1'b0, op_mul,  16'h0000, 16'h0000, 1'b0, 16'h0000, 1'b0, 1'b0},
        '{1'b0, op_mul,  16'h0000, 16'h0000, 1'b0, 16'h0000, 1'b0, 1'b0},
        // flags drop here
        '{1'b0, op_mul,  16'h0000, 16'h0000, 1'b1, 16'h0000, 1'b0, 1'b0},
        '{1'b1, op_mul,  16'h3C00, 16'h4000, 1'b0, 16'h4000, 1'b0, 1'b0},
        '{1'b1, op_mul,  16'h0400, 16'h0400, 1'b0, 16'h0000, 1'b0, 1'b1},
        '{1'b1, op_mul,  16'h3C00, 16'h3C00, 1'b0, 16'h3C00, 1'b0, 1'b0},
        // clear lands on the same edge as the unf set
        '{1'b0, op_mul,  16'h0000, 16'h0000, 1'b1, 16'h0000, 1'b0, 1'b0}
    };

    // drain filler, no req
    localparam vec_t IDLE_VEC = '{1'b0, op_mul, 16'h0, 16'h0, 1'b0, 16'h0, 1'b0, 1'b0};

    logic             clk;
    logic             nRST;
    logic             req;
    op_t              op;
    logic [TAG_W-1:0] tag;
    fp16_t            a;
    fp16_t            b;
    logic             clr_flags;
    logic             done;
    fp16_t            result;
    logic [TAG_W-1:0] result_tag;
    logic             ovf_flag;
    logic             unf_flag;

    pend_t       pend_q [$];
    logic [31:0] cyc;

    // sticky flag model and what the last edge saw
    logic model_ovf, model_unf;
    logic prev_clr, prev_done, prev_ovf, prev_unf;

    fpu_top #(.TAG_W(TAG_W)) uut (
        .clk       (clk),
        .nRST      (nRST),
        .req       (req),
        .op        (op),
        .tag       (tag),
        .a         (a),
        .b         (b),
        .clr_flags (clr_flags),
        .done      (done),
        .result    (result),
        .result_tag(result_tag),
        .ovf_flag  (ovf_flag),
        .unf_flag  (unf_flag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // outputs are stable at the falling edge
    task automatic observe_outputs();
        pend_t e;
        logic  exp_done;
        // replay the edge that just passed
        if (prev_clr) begin
            model_ovf = 1'b0;
            model_unf = 1'b0;
        end else if (prev_done) begin
            model_ovf = model_ovf | prev_ovf;
            model_unf = model_unf | prev_unf;
        end
        check("ovf_flag", 32'(ovf_flag), 32'(model_ovf));
        check("unf_flag", 32'(unf_flag), 32'(model_unf));
        exp_done = (pend_q.size() > 0) && (pend_q[0].due == cyc);
        check("done", 32'(done), 32'(exp_done));
        prev_done = done;
        prev_ovf = 1'b0;
        prev_unf = 1'b0;
        if (done) begin
            e = pend_q.pop_front();
            check("result", 32'(result), 32'(e.res));
            check("result_tag", 32'(result_tag), 32'(e.tag));
            prev_ovf = e.ovf;
            prev_unf = e.unf;
        end
    endtask

    task automatic apply_vector(input vec_t v);
        pend_t e;
        req = v.req;
        op = v.op;
        a = v.a;
        b = v.b;
        clr_flags = v.clr;
        tag = TAG_W'($urandom);
        prev_clr = v.clr;
        if (v.req) begin
            e.res = v.res;
            e.tag = tag;
            e.ovf = v.ovf;
            e.unf = v.unf;
            e.due = cyc + mul_lat;
            pend_q.push_back(e);
        end
    endtask

    // watchdog, sized from the table length
    initial begin
        #((NUM_VEC + 20) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(46402));
        nRST = 1'b0;
        req = 1'b0;
        op = op_mul;
        tag = '0;
        a = '0;
        b = '0;
        clr_flags = 1'b0;
        model_ovf = 1'b0;
        model_unf = 1'b0;
        prev_clr = 1'b0;
        prev_done = 1'b0;
        prev_ovf = 1'b0;
        prev_unf = 1'b0;
        cyc = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
        // table rows, then idle cycles to drain the pipe
        for (int i = 0; i < NUM_VEC + mul_lat + 2; i++) begin
            @(negedge clk);
            cyc = i;
            observe_outputs();
            if (i < NUM_VEC) begin
                apply_vector(VECS[i]);
            end else begin
                apply_vector(IDLE_VEC);
            end
        end
        check("results left in flight", pend_q.size(), 32'd0);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
src/fp16_pkg.sv
src/fpu_op_pkg.sv
src/stage_reg.sv
src/significand_mul.sv
src/exp_adder.sv
src/fp16_mul.sv
src/fpu_ctrl.sv
src/fpu_top.sv
verif/fpu_props.sv
verif/fpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the FP16 multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "cannot create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module fpu_tb \
    -Mdir "$BUILD_DIR/obj_dir" -o fpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/obj_dir/fpu_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "TB FAILED" "$LOG_FILE"; then
    echo "simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0
